//--- src.f
+incdir+verif
hw/box_pkg.sv
hw/box_cmd_decoder.sv
hw/box_table.sv
hw/box_overlay.sv
hw/box_overlay_top.sv
verif/tb_box_overlay.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_box_overlay -f src.f -o tb_box_overlay \
    && ./obj_dir/tb_box_overlay > sim.log 2>&1 \
    || echo "build or simulation did not complete"
cat sim.log 2>/dev/null
grep -qx "all tests passed" sim.log && exit 0 || exit 1

//--- verif/tb_box_model.svh
`ifndef TB_BOX_MODEL_SVH
`define TB_BOX_MODEL_SVH

// Mirror of the shadow and active tables and of the drawn output
box_t       m_shadow [N_BOX];
box_t       m_active [N_BOX];
logic [7:0] m_rec [$];
box_cmd_t   m_pend;
bit         m_pend_vld;
bit         m_vsync_q;
logic       m_err;
pix_pack_t  m_pipe [$];
int         m_painted;

function automatic bit on_border(box_t b, int x, int y);
    int sx = int'(b.start_x);
    int sy = int'(b.start_y);
    int ex = int'(b.end_x);
    int ey = int'(b.end_y);
    if (!b.en || x < sx || x > ex || y < sy || y > ey) begin
        return 1'b0;
    end
    return (x - sx < LINE_W) || (ex - x < LINE_W)
           || (y - sy < LINE_W) || (ey - y < LINE_W);
endfunction

// First box in index order whose border holds the pixel
function automatic pix_pack_t paint(pix_pack_t p);
    if (!p.de) begin
        return p;
    end
    for (int i = 0; i < N_BOX; i++) begin
        if (on_border(m_active[i], int'(p.x), int'(p.y))) begin
            {p.r, p.g, p.b} = m_active[i].color;
            return p;
        end
    end
    return p;
endfunction

function automatic void apply_cmd(box_cmd_t c);
    logic [X_W-1:0] x;
    logic [Y_W-1:0] y;
    {x, y} = c.payload[39 -: X_W+Y_W];
    for (int i = 0; i < N_BOX; i++) begin
        if (c.op == OP_CLEAR_ALL || (c.op == OP_CLEAR && int'(c.idx) == i)) begin
            m_shadow[i].en = 1'b0;
        end else if (c.op != OP_CLEAR && c.op != OP_CLEAR_ALL && int'(c.idx) == i) begin
            m_shadow[i].en = 1'b1;
            case (c.op)
                OP_SET_START: {m_shadow[i].start_x, m_shadow[i].start_y} = {x, y};
                OP_SET_END:   {m_shadow[i].end_x, m_shadow[i].end_y} = {x, y};
                default:      m_shadow[i].color = c.payload[39 -: 24];
            endcase
        end
    end
endfunction

task automatic model_reset();
    foreach (m_shadow[i]) begin
        m_shadow[i] = '0;
        m_active[i] = '0;
    end
    m_rec.delete();
    m_pipe.delete();
    m_pipe.push_back('0);
    m_pipe.push_back('0);
    m_pend_vld = 1'b0;
    m_vsync_q  = 1'b0;
    m_err      = 1'b0;
endtask

// One clock edge with the inputs the DUT samples on it
task automatic model_step(logic vld, logic [7:0] data, logic last, pix_pack_t p);
    box_cmd_t  c;
    pix_pack_t q;
    m_err = 1'b0;
    if (p.vsync && !m_vsync_q) begin
        m_active = m_shadow;
    end
    m_vsync_q = p.vsync;
    q = paint(p);
    if (q != p) begin
        m_painted++;
    end
    void'(m_pipe.pop_front());
    m_pipe.push_back(q);
    if (m_pend_vld) begin
        apply_cmd(m_pend);
    end
    m_pend_vld = 1'b0;
    if (vld) begin
        m_rec.push_back(data);
        if (m_rec.size() == CMD_BYTES) begin
            c = box_cmd_t'({m_rec[0], m_rec[1], m_rec[2], m_rec[3], m_rec[4], m_rec[5]});
            m_rec.delete();
            if (c.op >= OP_SET_START && c.op <= OP_CLEAR_ALL && int'(c.idx) < N_BOX) begin
                m_pend     = c;
                m_pend_vld = 1'b1;
            end else begin
                m_err = 1'b1;
            end
        end else if (last) begin
            m_rec.delete();
            m_err = 1'b1;
        end
    end
endtask

`endif

//--- verif/tb_box_overlay.sv
`timescale 1ns/1ps
`default_nettype none

module tb_box_overlay import box_pkg::*; ();

    localparam int N_BOX     = 4;
    localparam int LINE_W    = 2;
    localparam int N_FRAMES  = 9;
    localparam int FRAME_CYC = 600;
    localparam int VS_CYC    = 4;
    localparam int MAX_CYC   = N_FRAMES * FRAME_CYC + 8 + 100;

    logic        clk;
    logic        arst_n;
    logic        rx_valid;
    logic [7:0]  rx_data;
    logic        rx_last;
    pix_pack_t   pix_in;
    pix_pack_t   pix_out;
    logic        cmd_err;
    logic [31:0] lfsr = 32'h03e0_bed9;
    logic [8:0]  tx_q [$];
    int          cyc_cnt;
    int          pix_errors;
    int          flag_errors;
    int          other_errors;

    `include "tb_box_model.svh"

    box_overlay_top #(
        .N_BOX (N_BOX ),
        .LINE_W(LINE_W)
    ) uut (
        .clk       (clk     ),
        .i_arst_n  (arst_n  ),
        .i_rx_valid(rx_valid),
        .i_rx_data (rx_data ),
        .i_rx_last (rx_last ),
        .i_pix     (pix_in  ),
        .o_pix     (pix_out ),
        .o_cmd_err (cmd_err )
    );

    // Fibonacci LFSR with taps at bits 32, 22, 2 and 1
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic int rand_range(int lo, int span);
        return lo + int'(rand_bits(16) % span);
    endfunction

    task automatic queue_cmd(logic [2:0] op, int idx, logic [39:0] pl, logic last);
        logic [47:0] rec;
        rec = {op, 5'(idx), pl};
        for (int i = 5; i >= 0; i--) begin
            tx_q.push_back({last && i == 0, rec[i*8 +: 8]});
        end
    endtask

    task automatic queue_box(int idx, int sx, int sy);
        int ex;
        int ey;
        ex = sx + rand_range(4, 60);
        ey = sy + rand_range(4, 60);
        queue_cmd(OP_SET_START, idx, {X_W'(sx), Y_W'(sy), 19'd0}, 1'b0);
        queue_cmd(OP_SET_END, idx, {X_W'(ex), Y_W'(ey), 19'd0}, 1'b0);
        queue_cmd(OP_SET_COLOR, idx, {24'(rand_bits(24)), 16'd0}, 1'b1);
    endtask

    // Per frame commands where boxes share corners to overlap borders
    task automatic plan_frame(int f);
        int sx;
        int sy;
        sx = rand_range(0, 1100);
        sy = rand_range(0, 600);
        case (f)
            1: begin
                queue_box(0, sx, sy);
                queue_box(1, sx, sy);
            end
            2: begin
                queue_box(2, sx, sy);
                queue_box(3, sx + 2, sy + 1);
            end
            3: begin
                // Short payload, bad opcodes, bad indexes
                for (int i = 0; i < 3; i++) begin
                    tx_q.push_back({i == 2, 8'(rand_bits(8))});
                end
                queue_cmd(3'd0, 0, 40'(rand_bits(32)), 1'b0);
                queue_cmd(3'd6, 1, 40'(rand_bits(32)), 1'b0);
                queue_cmd(3'd7, 2, 40'(rand_bits(32)), 1'b0);
                queue_cmd(OP_SET_COLOR, 4, 40'(rand_bits(32)), 1'b0);
                queue_cmd(OP_CLEAR, 31, '0, 1'b1);
            end
            4: queue_cmd(OP_CLEAR, 1, '0, 1'b1);
            5: queue_cmd(OP_CLEAR_ALL, 0, '0, 1'b1);
            6: queue_box(2, sx, sy);
            7: queue_cmd(OP_CLEAR, 2, '0, 1'b1);
            default: begin
            end
        endcase
    endtask

    // Coordinates mostly near the edges of a table box
    function automatic pix_pack_t make_pix(int c);
        pix_pack_t p;
        box_t      b;
        int        x;
        int        y;
        b = m_shadow[2'(rand_bits(2))];
        x = rand_range(int'(b.start_x) - 3, int'(b.end_x) - int'(b.start_x) + 7);
        y = rand_range(int'(b.start_y) - 3, int'(b.end_y) - int'(b.start_y) + 7);
        case (rand_bits(2))
            0: x = rand_range(((rand_bits(1) != 0) ? int'(b.start_x) : int'(b.end_x)) - 3, 7);
            1: y = rand_range(((rand_bits(1) != 0) ? int'(b.start_y) : int'(b.end_y)) - 3, 7);
            2: begin
                x = rand_range(0, H_ACT);
                y = rand_range(0, V_ACT);
            end
            default: begin
            end
        endcase
        p.vsync       = c < VS_CYC;
        p.hsync       = rand_bits(4) == 0;
        p.de          = rand_bits(3) != 0;
        p.x           = X_W'(x);
        p.y           = Y_W'(y);
        {p.r, p.g, p.b} = 24'(rand_bits(24));
        return p;
    endfunction

    // Bytes start a quarter into the frame
    task automatic drive_cycle(int c);
        logic [8:0] t;
        pix_in <= make_pix(c);
        if (c >= FRAME_CYC / 4 && tx_q.size() > 0 && rand_bits(2) != 0) begin
            t = tx_q.pop_front();
            rx_valid <= 1'b1;
            rx_data  <= t[7:0];
            rx_last  <= t[8];
        end else begin
            rx_valid <= 1'b0;
            rx_data  <= 8'(rand_bits(8));
            rx_last  <= 1'b0;
        end
    endtask

    task automatic compare_pix(pix_pack_t got, pix_pack_t exp);
        if (got !== exp) begin
            pix_errors++;
            $display("mismatch at %0t: o_pix %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic compare_err(logic got, logic exp);
        if (got !== exp) begin
            flag_errors++;
            $display("mismatch at %0t: o_cmd_err %b, expected %b", $time, got, exp);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc_cnt <= cyc_cnt + 1;
        if (cyc_cnt >= MAX_CYC) begin
            $display("timeout, the run did not finish within %0d cycles", MAX_CYC);
            $display("tests failed");
            $finish;
        end
    end

    initial begin
        arst_n   <= 1'b0;
        rx_valid <= 1'b0;
        rx_data  <= '0;
        rx_last  <= 1'b0;
        pix_in   <= '0;
        model_reset();
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        model_step(rx_valid, rx_data, rx_last, pix_in);
        for (int f = 0; f < N_FRAMES; f++) begin
            plan_frame(f);
            for (int c = 0; c < FRAME_CYC; c++) begin
                @(posedge clk);
                drive_cycle(c);
                @(negedge clk);
                compare_pix(pix_out, m_pipe[0]);
                compare_err(cmd_err, m_err);
                model_step(rx_valid, rx_data, rx_last, pix_in);
            end
        end
        if (m_painted == 0) begin
            other_errors++;
            $display("no border pixel was drawn during the run");
        end
        $display("pixel errors %0d, error flag errors %0d, other errors %0d",
                 pix_errors, flag_errors, other_errors);
        if (pix_errors + flag_errors + other_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule : tb_box_overlay

`default_nettype wire

//--- hw/box_overlay_top.sv
`timescale 1ns/1ps
`default_nettype none

module box_overlay_top import box_pkg::*; #(
    parameter int N_BOX  = 4,
    parameter int LINE_W = 2
) (
    input  wire             clk,
    input  wire             i_arst_n,
    // Payload byte stream
    input  wire             i_rx_valid,
    input  wire  [7:0]      i_rx_data,
    input  wire             i_rx_last,
    // Pixel stream
    input  wire  pix_pack_t i_pix,
    output pix_pack_t       o_pix,
    output logic            o_cmd_err
);

    box_cmd_t         cmd;
    logic             cmd_valid;
    box_t [N_BOX-1:0] boxes;

    box_cmd_decoder #(
        .N_BOX(N_BOX)
    ) u_decoder (
        .clk        (clk       ),
        .i_arst_n   (i_arst_n  ),
        .i_rx_valid (i_rx_valid),
        .i_rx_data  (i_rx_data ),
        .i_rx_last  (i_rx_last ),
        .o_cmd      (cmd       ),
        .o_cmd_valid(cmd_valid ),
        .o_cmd_err  (o_cmd_err )
    );

    box_table #(
        .N_BOX(N_BOX)
    ) u_table (
        .clk        (clk        ),
        .i_arst_n   (i_arst_n   ),
        .i_cmd      (cmd        ),
        .i_cmd_valid(cmd_valid  ),
        .i_vsync    (i_pix.vsync),
        .o_boxes    (boxes      )
    );

    box_overlay #(
        .N_BOX (N_BOX ),
        .LINE_W(LINE_W)
    ) u_overlay (
        .clk     (clk     ),
        .i_arst_n(i_arst_n),
        .i_boxes (boxes   ),
        .i_pix   (i_pix   ),
        .o_pix   (o_pix   )
    );

endmodule : box_overlay_top

`default_nettype wire

//--- hw/box_overlay.sv
`timescale 1ns/1ps
`default_nettype none

module box_overlay import box_pkg::*; #(
    parameter int N_BOX  = 4,
    parameter int LINE_W = 2
) (
    input  wire                    clk,
    input  wire                    i_arst_n,
    input  wire  box_t [N_BOX-1:0] i_boxes,
    input  wire  pix_pack_t        i_pix,
    output pix_pack_t              o_pix
);

    localparam logic [X_W:0] LW_X = (X_W+1)'(LINE_W);
    localparam logic [Y_W:0] LW_Y = (Y_W+1)'(LINE_W);

    logic [X_W:0]            px;
    logic [Y_W:0]            py;
    logic [N_BOX-1:0]        hit;
    pix_pack_t               pix_s1;
    logic [N_BOX-1:0]        hit_s1;
    logic [N_BOX-1:0][23:0]  color_s1;
    logic                    sel_hit;
    logic [23:0]             sel_rgb;

    // One extra bit keeps edge sums from wrapping
    assign px = {1'b0, i_pix.x};
    assign py = {1'b0, i_pix.y};

    always_comb begin
        logic [X_W:0] sx;
        logic [X_W:0] ex;
        logic [Y_W:0] sy;
        logic [Y_W:0] ey;
        logic         in_rect;
        logic         on_edge;
        hit = '0;
        for (int i = 0; i < N_BOX; i++) begin
            sx = {1'b0, i_boxes[i].start_x};
            ex = {1'b0, i_boxes[i].end_x};
            sy = {1'b0, i_boxes[i].start_y};
            ey = {1'b0, i_boxes[i].end_y};
            in_rect = (px >= sx) && (px <= ex) && (py >= sy) && (py <= ey);
            // Within LINE_W of left, right, top or bottom
            on_edge = (px < sx + LW_X) || (px + LW_X > ex)
                      || (py < sy + LW_Y) || (py + LW_Y > ey);
            hit[i] = i_boxes[i].en && i_pix.de && in_rect && on_edge;
        end
    end

    // Stage 1
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pix_s1 <= '0;
            hit_s1 <= '0;
        end else begin
            pix_s1 <= i_pix;
            hit_s1 <= hit;
        end
    end

    // Colours travel with the hits across a table commit
    always_ff @(posedge clk) begin
        for (int i = 0; i < N_BOX; i++) begin
            color_s1[i] <= i_boxes[i].color;
        end
    end

    // Lowest index wins
    always_comb begin
        sel_hit = 1'b0;
        sel_rgb = '0;
        for (int i = N_BOX - 1; i >= 0; i--) begin
            if (hit_s1[i]) begin
                sel_hit = 1'b1;
                sel_rgb = color_s1[i];
            end
        end
    end

    // Stage 2
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_pix <= '0;
        end else begin
            o_pix <= pix_s1;
            if (sel_hit) begin
                {o_pix.r, o_pix.g, o_pix.b} <= sel_rgb;
            end
        end
    end

endmodule : box_overlay

`default_nettype wire

//--- hw/box_table.sv
`timescale 1ns/1ps
`default_nettype none

module box_table import box_pkg::*; #(
    parameter int N_BOX = 4
) (
    input  wire                    clk,
    input  wire                    i_arst_n,
    input  wire  box_cmd_t         i_cmd,
    input  wire                    i_cmd_valid,
    input  wire                    i_vsync,
    output box_t [N_BOX-1:0]       o_boxes
);

    box_t [N_BOX-1:0] shadow;
    box_t [N_BOX-1:0] active;
    logic             vsync_q;
    logic             frame_start;
    logic [X_W-1:0]   cmd_x;
    logic [Y_W-1:0]   cmd_y;
    logic [23:0]      cmd_rgb;

    // Payload fields, left aligned
    assign cmd_x   = i_cmd.payload[39 -: X_W];
    assign cmd_y   = i_cmd.payload[39-X_W -: Y_W];
    assign cmd_rgb = i_cmd.payload[39 -: 24];

    assign frame_start = i_vsync && !vsync_q;

    // The vsync pack already sees the table it commits
    assign o_boxes = frame_start ? shadow : active;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            shadow <= '0;
        end else if (i_cmd_valid) begin
            for (int i = 0; i < N_BOX; i++) begin
                if (i_cmd.op == OP_CLEAR_ALL || 32'(i_cmd.idx) == i) begin
                    case (i_cmd.op)
                        OP_SET_START: begin
                            shadow[i].start_x <= cmd_x;
                            shadow[i].start_y <= cmd_y;
                            shadow[i].en      <= 1'b1;
                        end
                        OP_SET_END: begin
                            shadow[i].end_x <= cmd_x;
                            shadow[i].end_y <= cmd_y;
                            shadow[i].en    <= 1'b1;
                        end
                        OP_SET_COLOR: begin
                            shadow[i].color <= cmd_rgb;
                            shadow[i].en    <= 1'b1;
                        end
                        OP_CLEAR, OP_CLEAR_ALL: begin
                            shadow[i].en <= 1'b0;
                        end
                        default: begin
                        end
                    endcase
                end
            end
        end
    end

    // Commit on vsync rise only, so no box tears mid frame
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            vsync_q <= 1'b0;
            active  <= '0;
        end else begin
            vsync_q <= i_vsync;
            if (frame_start) begin
                active <= shadow;
            end
        end
    end

endmodule : box_table

`default_nettype wire

//--- hw/box_cmd_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module box_cmd_decoder import box_pkg::*; #(
    parameter int N_BOX = 4
) (
    input  wire        clk,
    input  wire        i_arst_n,
    input  wire        i_rx_valid,
    input  wire  [7:0] i_rx_data,
    input  wire        i_rx_last,
    output box_cmd_t   o_cmd,
    output logic       o_cmd_valid,
    output logic       o_cmd_err
);

    typedef enum logic {
        IDLE,
        COLLECT
    } dec_state_e;

    dec_state_e  state;
    logic [2:0]  byte_cnt;
    logic [39:0] rec;
    logic [47:0] full_rec;
    box_cmd_t    new_cmd;
    logic        rec_done;
    logic        op_ok;
    logic        idx_ok;

    // Sixth byte completes the record with the incoming byte
    assign full_rec = {rec, i_rx_data};
    assign new_cmd  = box_cmd_t'(full_rec);
    assign rec_done = i_rx_valid && (state == COLLECT)
                      && (byte_cnt == 3'(CMD_BYTES - 1));

    assign op_ok  = new_cmd.op inside {OP_SET_START, OP_SET_END, OP_SET_COLOR,
                                       OP_CLEAR, OP_CLEAR_ALL};
    assign idx_ok = 32'(new_cmd.idx) < N_BOX;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state       <= IDLE;
            byte_cnt    <= '0;
            o_cmd_valid <= 1'b0;
            o_cmd_err   <= 1'b0;
        end else begin
            o_cmd_valid <= 1'b0;
            o_cmd_err   <= 1'b0;
            if (i_rx_valid) begin
                if (rec_done) begin
                    state       <= IDLE;
                    byte_cnt    <= '0;
                    o_cmd_valid <= op_ok && idx_ok;
                    o_cmd_err   <= !(op_ok && idx_ok);
                end else if (i_rx_last) begin
                    // Payload ended mid record
                    state     <= IDLE;
                    byte_cnt  <= '0;
                    o_cmd_err <= 1'b1;
                end else begin
                    state    <= COLLECT;
                    byte_cnt <= byte_cnt + 3'd1;
                end
            end
        end
    end

    // Byte shifter and command register
    always_ff @(posedge clk) begin
        if (i_rx_valid) begin
            rec <= {rec[31:0], i_rx_data};
        end
        if (rec_done) begin
            o_cmd <= new_cmd;
        end
    end

endmodule : box_cmd_decoder

`default_nettype wire

//--- hw/box_pkg.sv
`default_nettype none

package box_pkg;

    // Active frame size
    localparam int H_ACT = 1280;
    localparam int V_ACT = 720;

    localparam int X_W = $clog2(H_ACT);
    localparam int Y_W = $clog2(V_ACT);

    // One command record on the payload stream
    localparam int CMD_BYTES = 6;

    // Codes 0, 6 and 7 are rejected by the decoder
    typedef enum logic [2:0] {
        OP_SET_START = 3'd1,
        OP_SET_END   = 3'd2,
        OP_SET_COLOR = 3'd3,
        OP_CLEAR     = 3'd4,
        OP_CLEAR_ALL = 3'd5
    } box_op_e;

    // Byte 0 is {op, idx}, bytes 1..5 the payload, MSB first
    typedef struct packed {
        box_op_e     op;
        logic [4:0]  idx;
        logic [39:0] payload;
    } box_cmd_t;

    typedef struct packed {
        logic           en;
        logic [X_W-1:0] start_x;
        logic [Y_W-1:0] start_y;
        logic [X_W-1:0] end_x;
        logic [Y_W-1:0] end_y;
        logic [23:0]    color;
    } box_t;

    // Pixel with its own coordinates
    typedef struct packed {
        logic           vsync;
        logic           hsync;
        logic           de;
        logic [X_W-1:0] x;
        logic [Y_W-1:0] y;
        logic [7:0]     r;
        logic [7:0]     g;
        logic [7:0]     b;
    } pix_pack_t;

endpackage : box_pkg

`default_nettype wire
